// ==== include/ooo_cfg.svh ====
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// Reorder buffer entries as a power of two
`define OOO_ROB_DEPTH 8

// Reservation station entries
`define OOO_RS_DEPTH 4

// Architectural registers and datapath width
`define OOO_NUM_REGS 8
`define OOO_XLEN 32

`endif

// ==== source/ooo_pkg.sv ====
`include "ooo_cfg.svh"

package ooo_pkg;

  typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_ix_t;
  typedef logic [$clog2(`OOO_NUM_REGS)-1:0] reg_ix_t;
  typedef logic signed [`OOO_XLEN-1:0] word_t;

  // SLL shifts by the low five bits of operand two
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_ADDI = 3'd5,
    OP_SLL  = 3'd6
  } alu_op_e;

  // ADDI takes imm in place of rs2
  typedef struct packed {
    alu_op_e            op;
    reg_ix_t            rd;
    reg_ix_t            rs1;
    reg_ix_t            rs2;
    logic signed [15:0] imm;
  } instr_t;

  // Value is meaningful only when ready, tag only when not
  typedef struct packed {
    logic    ready;
    word_t   value;
    rob_ix_t tag;
  } operand_t;

  typedef struct packed {
    alu_op_e  op;
    operand_t src1;
    operand_t src2;
    rob_ix_t  dest;
  } rs_entry_t;

  typedef struct packed {
    logic    valid;
    rob_ix_t tag;
    word_t   value;
  } cdb_t;

  typedef struct packed {
    reg_ix_t rd;
    rob_ix_t rob_ix;
    word_t   value;
  } commit_t;

endpackage

// ==== source/reg_status.sv ====
`include "ooo_cfg.svh"

module reg_status (
  input  logic               clk_in,
  input  logic               rst_in,
  input  ooo_pkg::reg_ix_t   rs1,
  input  ooo_pkg::reg_ix_t   rs2,
  input  logic               alloc_valid,
  input  ooo_pkg::reg_ix_t   alloc_rd,
  input  ooo_pkg::rob_ix_t   alloc_tag,
  input  logic               commit_valid,
  input  ooo_pkg::commit_t   commit,
  output ooo_pkg::operand_t  op1_info,
  output ooo_pkg::operand_t  op2_info
);

  localparam int NREGS = `OOO_NUM_REGS;

  ooo_pkg::word_t           regs_q [NREGS];
  ooo_pkg::rob_ix_t         tags_q [NREGS];
  logic [NREGS-1:0]         busy_q;

  // Ready means no producer is in flight for this register
  always_comb begin
    op1_info.ready = ~busy_q[rs1];
    op1_info.value = regs_q[rs1];
    op1_info.tag   = tags_q[rs1];
    op2_info.ready = ~busy_q[rs2];
    op2_info.value = regs_q[rs2];
    op2_info.tag   = tags_q[rs2];
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy_q <= '0;
      for (int i = 0; i < NREGS; i++) begin
        regs_q[i] <= '0;
        tags_q[i] <= '0;
      end
    end else begin
      if (commit_valid) begin
        regs_q[commit.rd] <= commit.value;
        // A younger producer may have claimed rd since
        if (busy_q[commit.rd] && tags_q[commit.rd] == commit.rob_ix) begin
          busy_q[commit.rd] <= 1'b0;
        end
      end
      // Later assignment, so a same-cycle alloc keeps rd busy
      if (alloc_valid) begin
        busy_q[alloc_rd] <= 1'b1;
        tags_q[alloc_rd] <= alloc_tag;
      end
    end
  end

endmodule

// ==== source/rob.sv ====
`include "ooo_cfg.svh"

module rob (
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic               alloc_valid,
  input  ooo_pkg::reg_ix_t   alloc_rd,
  input  ooo_pkg::rob_ix_t   lookup1_tag,
  input  ooo_pkg::rob_ix_t   lookup2_tag,
  input  ooo_pkg::cdb_t      cdb,
  output logic               space,
  output ooo_pkg::rob_ix_t   tail_tag,
  output ooo_pkg::operand_t  lookup1,
  output ooo_pkg::operand_t  lookup2,
  output logic               commit_valid,
  output ooo_pkg::commit_t   commit
);

  localparam int DEPTH = `OOO_ROB_DEPTH;
  localparam int IW    = $clog2(DEPTH);

  // Pointers carry an extra wrap bit to tell full from empty
  logic [IW:0]        head_q;
  logic [IW:0]        tail_q;
  logic [IW:0]        count;
  logic [DEPTH-1:0]   done_q;
  ooo_pkg::reg_ix_t   rd_q  [DEPTH];
  ooo_pkg::word_t     val_q [DEPTH];
  ooo_pkg::rob_ix_t   head_ix;

  assign count    = tail_q - head_q;
  assign head_ix  = head_q[IW-1:0];
  assign tail_tag = tail_q[IW-1:0];

  // Count never exceeds DEPTH, so the top bit alone flags full
  assign space        = ~count[IW];
  assign commit_valid = (count != '0) && done_q[head_ix];

  assign commit.rd     = rd_q[head_ix];
  assign commit.rob_ix = head_ix;
  assign commit.value  = val_q[head_ix];

  // Forwarding for dispatch
  always_comb begin
    lookup1.ready = done_q[lookup1_tag];
    lookup1.value = val_q[lookup1_tag];
    lookup1.tag   = lookup1_tag;
    lookup2.ready = done_q[lookup2_tag];
    lookup2.value = val_q[lookup2_tag];
    lookup2.tag   = lookup2_tag;
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      head_q <= '0;
      tail_q <= '0;
      done_q <= '0;
    end else begin
      if (alloc_valid) begin
        done_q[tail_tag] <= 1'b0;
        tail_q           <= tail_q + 1'b1;
      end
      // CDB tag always names an in-flight entry, never the tail slot
      if (cdb.valid) begin
        done_q[cdb.tag] <= 1'b1;
      end
      if (commit_valid) begin
        head_q <= head_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (alloc_valid) begin
      rd_q[tail_tag] <= alloc_rd;
    end
    if (cdb.valid) begin
      val_q[cdb.tag] <= cdb.value;
    end
  end

endmodule

// ==== source/dispatch_unit.sv ====
`include "ooo_cfg.svh"

module dispatch_unit (
  input  logic                in_valid,
  input  ooo_pkg::instr_t     instr,
  input  ooo_pkg::operand_t   reg_op1,
  input  ooo_pkg::operand_t   reg_op2,
  input  ooo_pkg::operand_t   rob_op1,
  input  ooo_pkg::operand_t   rob_op2,
  input  logic                rob_space,
  input  logic                rs_space,
  input  ooo_pkg::rob_ix_t    tail_tag,
  output logic                in_ready,
  output ooo_pkg::rob_ix_t    lookup1_tag,
  output ooo_pkg::rob_ix_t    lookup2_tag,
  output logic                alloc_valid,
  output ooo_pkg::reg_ix_t    alloc_rd,
  output logic                rs_write,
  output ooo_pkg::rs_entry_t  rs_entry
);

  // Register file first, then a finished but uncommitted producer
  function automatic ooo_pkg::operand_t resolve(ooo_pkg::operand_t from_reg,
                                                ooo_pkg::operand_t from_rob);
    ooo_pkg::operand_t res;
    res = from_reg;
    if (!from_reg.ready && from_rob.ready) begin
      res.ready = 1'b1;
      res.value = from_rob.value;
    end
    return res;
  endfunction

  ooo_pkg::word_t imm_ext;

  assign imm_ext = {{(`OOO_XLEN-16){instr.imm[15]}}, instr.imm};

  // Forwarding lookups follow the producer tags from the status table
  assign lookup1_tag = reg_op1.tag;
  assign lookup2_tag = reg_op2.tag;

  assign in_ready    = rob_space & rs_space;
  assign alloc_valid = in_valid & in_ready;
  assign rs_write    = alloc_valid;
  assign alloc_rd    = instr.rd;

  always_comb begin
    rs_entry.op   = instr.op;
    rs_entry.dest = tail_tag;
    rs_entry.src1 = resolve(reg_op1, rob_op1);
    if (instr.op == ooo_pkg::OP_ADDI) begin
      rs_entry.src2.ready = 1'b1;
      rs_entry.src2.value = imm_ext;
      rs_entry.src2.tag   = '0;
    end else begin
      rs_entry.src2 = resolve(reg_op2, rob_op2);
    end
  end

endmodule

// ==== source/reservation_station.sv ====
`include "ooo_cfg.svh"

module reservation_station (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                write,
  input  ooo_pkg::rs_entry_t  entry,
  input  ooo_pkg::cdb_t       cdb,
  output logic                space,
  output logic                issue_valid,
  output ooo_pkg::rs_entry_t  issue
);

  localparam int DEPTH = `OOO_RS_DEPTH;
  localparam int IXW   = $clog2(DEPTH);

  function automatic ooo_pkg::operand_t wake_op(ooo_pkg::operand_t op, ooo_pkg::cdb_t bus);
    ooo_pkg::operand_t res;
    res = op;
    if (!op.ready && bus.valid && bus.tag == op.tag) begin
      res.ready = 1'b1;
      res.value = bus.value;
    end
    return res;
  endfunction

  function automatic ooo_pkg::rs_entry_t wake_entry(ooo_pkg::rs_entry_t e, ooo_pkg::cdb_t bus);
    ooo_pkg::rs_entry_t res;
    res      = e;
    res.src1 = wake_op(e.src1, bus);
    res.src2 = wake_op(e.src2, bus);
    return res;
  endfunction

  // Slot 0 holds the oldest entry
  ooo_pkg::rs_entry_t slots_q    [DEPTH];
  ooo_pkg::rs_entry_t woken      [DEPTH];
  ooo_pkg::rs_entry_t next_slots [DEPTH];
  ooo_pkg::rs_entry_t in_woken;
  logic [DEPTH-1:0]   valid_q;
  logic [DEPTH-1:0]   next_valid;
  logic               issue_hit;
  logic [IXW-1:0]     issue_ix;

  assign space = ~(&valid_q);

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      woken[i] = wake_entry(slots_q[i], cdb);
    end
    in_woken = wake_entry(entry, cdb);
  end

  // Scan downward so the lowest (oldest) ready slot wins
  always_comb begin
    issue_hit = 1'b0;
    issue_ix  = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (valid_q[i] && slots_q[i].src1.ready && slots_q[i].src2.ready) begin
        issue_hit = 1'b1;
        issue_ix  = i[IXW-1:0];
      end
    end
  end

  assign issue_valid = issue_hit;
  assign issue       = slots_q[issue_ix];

  // Drop the issued slot, close the gap, then append the new entry
  always_comb begin
    int unsigned fill;
    fill       = 0;
    next_valid = '0;
    for (int i = 0; i < DEPTH; i++) begin
      next_slots[i] = woken[i];
    end
    for (int i = 0; i < DEPTH; i++) begin
      if (valid_q[i] && !(issue_hit && issue_ix == i[IXW-1:0])) begin
        next_slots[fill] = woken[i];
        next_valid[fill] = 1'b1;
        fill             = fill + 1;
      end
    end
    // Write is only accepted with a free slot, so fill stays in range
    if (write) begin
      next_slots[fill] = in_woken;
      next_valid[fill] = 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_q <= '0;
    end else begin
      valid_q <= next_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    for (int i = 0; i < DEPTH; i++) begin
      slots_q[i] <= next_slots[i];
    end
  end

endmodule

// ==== source/alu_pipe.sv ====
module alu_pipe (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                issue_valid,
  input  ooo_pkg::rs_entry_t  issue,
  output ooo_pkg::cdb_t       cdb
);

  ooo_pkg::word_t   result;
  logic             s1_valid;
  ooo_pkg::rob_ix_t s1_tag;
  ooo_pkg::word_t   s1_result;

  always_comb begin
    case (issue.op)
      // Immediate already sits in operand two for ADDI
      ooo_pkg::OP_ADD,
      ooo_pkg::OP_ADDI: result = issue.src1.value + issue.src2.value;
      ooo_pkg::OP_SUB:  result = issue.src1.value - issue.src2.value;
      ooo_pkg::OP_AND:  result = issue.src1.value & issue.src2.value;
      ooo_pkg::OP_OR:   result = issue.src1.value | issue.src2.value;
      ooo_pkg::OP_XOR:  result = issue.src1.value ^ issue.src2.value;
      ooo_pkg::OP_SLL:  result = issue.src1.value << issue.src2.value[4:0];
      default:          result = '0;
    endcase
  end

  // Stage one holds the computed result
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= issue_valid;
    end
    s1_tag    <= issue.dest;
    s1_result <= result;
  end

  // Stage two registers the result onto the CDB
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      cdb.valid <= 1'b0;
    end else begin
      cdb.valid <= s1_valid;
    end
    cdb.tag   <= s1_tag;
    cdb.value <= s1_result;
  end

endmodule

// ==== source/ooo_core_top.sv ====
module ooo_core_top (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              in_valid,
  input  ooo_pkg::instr_t   instr,
  output logic              in_ready,
  output logic              commit_valid,
  output ooo_pkg::commit_t  commit
);

  ooo_pkg::operand_t  reg_op1;
  ooo_pkg::operand_t  reg_op2;
  ooo_pkg::operand_t  rob_op1;
  ooo_pkg::operand_t  rob_op2;
  ooo_pkg::rob_ix_t   lookup1_tag;
  ooo_pkg::rob_ix_t   lookup2_tag;
  ooo_pkg::rob_ix_t   tail_tag;
  ooo_pkg::reg_ix_t   alloc_rd;
  ooo_pkg::rs_entry_t rs_entry;
  ooo_pkg::rs_entry_t issue;
  ooo_pkg::cdb_t      cdb;
  logic               rob_space;
  logic               rs_space;
  logic               alloc_valid;
  logic               rs_write;
  logic               issue_valid;

  reg_status reg_status_inst (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rs1          (instr.rs1),
    .rs2          (instr.rs2),
    .alloc_valid  (alloc_valid),
    .alloc_rd     (alloc_rd),
    .alloc_tag    (tail_tag),
    .commit_valid (commit_valid),
    .commit       (commit),
    .op1_info     (reg_op1),
    .op2_info     (reg_op2)
  );

  rob rob_inst (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .alloc_valid  (alloc_valid),
    .alloc_rd     (alloc_rd),
    .lookup1_tag  (lookup1_tag),
    .lookup2_tag  (lookup2_tag),
    .cdb          (cdb),
    .space        (rob_space),
    .tail_tag     (tail_tag),
    .lookup1      (rob_op1),
    .lookup2      (rob_op2),
    .commit_valid (commit_valid),
    .commit       (commit)
  );

  dispatch_unit dispatch_unit_inst (
    .in_valid    (in_valid),
    .instr       (instr),
    .reg_op1     (reg_op1),
    .reg_op2     (reg_op2),
    .rob_op1     (rob_op1),
    .rob_op2     (rob_op2),
    .rob_space   (rob_space),
    .rs_space    (rs_space),
    .tail_tag    (tail_tag),
    .in_ready    (in_ready),
    .lookup1_tag (lookup1_tag),
    .lookup2_tag (lookup2_tag),
    .alloc_valid (alloc_valid),
    .alloc_rd    (alloc_rd),
    .rs_write    (rs_write),
    .rs_entry    (rs_entry)
  );

  reservation_station reservation_station_inst (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .write       (rs_write),
    .entry       (rs_entry),
    .cdb         (cdb),
    .space       (rs_space),
    .issue_valid (issue_valid),
    .issue       (issue)
  );

  alu_pipe alu_pipe_inst (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .issue_valid (issue_valid),
    .issue       (issue),
    .cdb         (cdb)
  );

endmodule

// ==== dv/ooo_ref_model.sv ====
`include "ooo_cfg.svh"

module ooo_ref_model;

  // Architectural state as seen by an in-order machine
  ooo_pkg::word_t regs [`OOO_NUM_REGS];

  task automatic reset_regs();
    for (int i = 0; i < `OOO_NUM_REGS; i++) begin
      regs[i] = '0;
    end
  endtask

  // Runs one instruction in program order, returns the value written to rd
  task automatic execute(input ooo_pkg::instr_t ins, output ooo_pkg::word_t result);
    ooo_pkg::word_t a;
    ooo_pkg::word_t b;
    ooo_pkg::word_t imm_val;
    a       = regs[ins.rs1];
    b       = regs[ins.rs2];
    // Signed 16-bit immediate widened to a full word
    imm_val = ins.imm;
    case (ins.op)
      ooo_pkg::OP_ADD: begin
        result = a + b;
      end
      ooo_pkg::OP_SUB: begin
        result = a - b;
      end
      ooo_pkg::OP_AND: begin
        result = a & b;
      end
      ooo_pkg::OP_OR: begin
        result = a | b;
      end
      ooo_pkg::OP_XOR: begin
        result = a ^ b;
      end
      ooo_pkg::OP_ADDI: begin
        result = a + imm_val;
      end
      ooo_pkg::OP_SLL: begin
        result = a << b[4:0];
      end
      default: begin
        result = '0;
      end
    endcase
    regs[ins.rd] = result;
  endtask

endmodule

// ==== dv/ooo_core_tb.sv ====
`include "ooo_cfg.svh"

module ooo_core_tb;

  localparam int NUM_INSTR  = 400;
  localparam int BURST_FROM = 300;
  localparam int NUM_OPS    = 7;
  localparam int TIMEOUT    = 20 * NUM_INSTR + 100;

  logic             clk_in;
  logic             rst_in;
  logic             in_valid;
  ooo_pkg::instr_t  instr;
  logic             in_ready;
  logic             commit_valid;
  ooo_pkg::commit_t commit;

  integer           seed;
  int               errors;
  int               accepted;
  int               commits;
  int               cycles;
  int               op_count [NUM_OPS];
  ooo_pkg::commit_t expected_q [$];

  ooo_core_top ooo_core_top_inst (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .in_valid     (in_valid),
    .instr        (instr),
    .in_ready     (in_ready),
    .commit_valid (commit_valid),
    .commit       (commit)
  );

  ooo_ref_model ooo_ref_model_inst ();

  initial begin
    clk_in = 1'b0;
    forever #5 clk_in = ~clk_in;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  function automatic ooo_pkg::instr_t random_instr();
    ooo_pkg::instr_t ins;
    int unsigned     op_num;
    op_num  = $unsigned($random(seed)) % NUM_OPS;
    ins.op  = ooo_pkg::alu_op_e'(op_num[2:0]);
    ins.rd  = ooo_pkg::reg_ix_t'($random(seed));
    ins.rs1 = ooo_pkg::reg_ix_t'($random(seed));
    ins.rs2 = ooo_pkg::reg_ix_t'($random(seed));
    ins.imm = 16'($random(seed));
    return ins;
  endfunction

  // Model runs on every accepted transfer and each commit pops its queue
  always @(posedge clk_in) begin
    ooo_pkg::commit_t exp_c;
    ooo_pkg::word_t   value;
    if (!rst_in) begin
      if (in_valid && in_ready) begin
        ooo_ref_model_inst.execute(instr, value);
        exp_c.rd     = instr.rd;
        exp_c.rob_ix = ooo_pkg::rob_ix_t'(accepted % `OOO_ROB_DEPTH);
        exp_c.value  = value;
        expected_q.push_back(exp_c);
        op_count[int'(instr.op)]++;
        accepted++;
      end
      if (commit_valid) begin
        if (expected_q.size() == 0) begin
          $display("Commit seen with no accepted instruction outstanding");
          errors++;
        end else begin
          exp_c = expected_q.pop_front();
          check_value("commit.rd", 32'(commit.rd), 32'(exp_c.rd));
          check_value("commit.rob_ix", 32'(commit.rob_ix), 32'(exp_c.rob_ix));
          check_value("commit.value", commit.value, exp_c.value);
        end
        commits++;
      end
      if (accepted - commits > `OOO_ROB_DEPTH) begin
        $display("More instructions in flight (%0d) than reorder buffer entries",
                 accepted - commits);
        errors++;
      end
    end
  end

  always @(posedge clk_in) begin
    cycles++;
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles with %0d of %0d instructions committed",
               cycles, commits, NUM_INSTR);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    int gap;
    seed     = 32'h01e96f21;
    errors   = 0;
    accepted = 0;
    commits  = 0;
    cycles   = 0;
    for (int i = 0; i < NUM_OPS; i++) begin
      op_count[i] = 0;
    end
    in_valid = 1'b0;
    instr    = '0;
    rst_in   = 1'b1;
    ooo_ref_model_inst.reset_regs();
    repeat (4) @(posedge clk_in);
    #1 rst_in = 1'b0;

    // Idle core accepts and has nothing to retire
    repeat (5) begin
      @(posedge clk_in);
      check_value("in_ready", 32'(in_ready), 32'd1);
      check_value("commit_valid", 32'(commit_valid), 32'd0);
    end
    #1;

    // Random gaps first, then a back-to-back burst
    for (int n = 0; n < NUM_INSTR; n++) begin
      gap = 0;
      if (n < BURST_FROM && ($random(seed) & 3) == 0) begin
        gap = 1 + ($unsigned($random(seed)) % 4);
      end
      repeat (gap) begin
        @(posedge clk_in);
        #1;
      end
      in_valid = 1'b1;
      instr    = random_instr();
      @(posedge clk_in);
      while (!in_ready) @(posedge clk_in);
      #1 in_valid = 1'b0;
    end

    while (commits < NUM_INSTR) @(posedge clk_in);
    // Idle tail catches any extra commit
    repeat (10) @(posedge clk_in);
    #1;
    for (int i = 0; i < NUM_OPS; i++) begin
      if (op_count[i] == 0) begin
        $display("Opcode %0d was never sent to the core", i);
        errors++;
      end
    end
    $display("Summary: %0d errors, %0d accepted, %0d committed", errors, accepted, commits);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
source/ooo_pkg.sv
source/reg_status.sv
source/rob.sv
source/dispatch_unit.sv
source/reservation_station.sv
source/alu_pipe.sv
source/ooo_core_top.sv
dv/ooo_ref_model.sv
dv/ooo_core_tb.sv

// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - include_dirs:
      - include
    files:
      - source/ooo_pkg.sv
      - source/reg_status.sv
      - source/rob.sv
      - source/dispatch_unit.sv
      - source/reservation_station.sv
      - source/alu_pipe.sv
      - source/ooo_core_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/ooo_ref_model.sv
      - dv/ooo_core_tb.sv
